//--- ofdm_defs.svh
`ifndef OFDM_DEFS_SVH
`define OFDM_DEFS_SVH

// sample and symbol sizes
`define OFDM_SAMPLE_W    16
`define OFDM_N_BINS      256
`define OFDM_N_DATA      192

// one group fills eight data subcarriers
`define OFDM_GROUP_SC    8
`define OFDM_GROUP_BITS  32

// constellation and pilot levels
`define OFDM_AMP         1024
`define OFDM_PILOT_AMP   1024

// guard band, both ends included
`define OFDM_GUARD_LO    101
`define OFDM_GUARD_HI    155

// pilots 0..3 positive, 4..7 negative
`define OFDM_PILOT_BIN_0 13
`define OFDM_PILOT_BIN_1 38
`define OFDM_PILOT_BIN_2 63
`define OFDM_PILOT_BIN_3 88
`define OFDM_PILOT_BIN_4 168
`define OFDM_PILOT_BIN_5 193
`define OFDM_PILOT_BIN_6 218
`define OFDM_PILOT_BIN_7 243

`endif

//--- ofdm_pkg.sv
`include "ofdm_defs.svh"

package ofdm_pkg;

    //////////////////////////////
    // modulation select
    //////////////////////////////

    // code 3 is not listed, treated as BPSK
    typedef enum logic [1:0]
    {
        BPSK  = 2'd0,
        QPSK  = 2'd1,
        QAM16 = 2'd2
    } mod_t;

    //////////////////////////////
    // payload types
    //////////////////////////////

    // one complex point
    typedef struct packed
    {
        logic signed [`OFDM_SAMPLE_W-1:0] i;
        logic signed [`OFDM_SAMPLE_W-1:0] q;
    } cplx_t;

    // packed bytes of one group plus its modulation
    typedef struct packed
    {
        mod_t                        mode;
        logic [`OFDM_GROUP_BITS-1:0] bits;
    } bit_group_t;

    // mapped points of one group, subcarrier 0 in sc[0]
    typedef struct packed
    {
        cplx_t [`OFDM_GROUP_SC-1:0] sc;
    } point_group_t;

endpackage

//--- ofdm_byte_packer.sv
`timescale 1ns/1ps
`include "ofdm_defs.svh"

module ofdm_byte_packer
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 data_en_i,
    input  logic [7:0]           data_i,
    input  ofdm_pkg::mod_t       mod_i,
    input  logic                 sym_end_i,
    input  logic                 full_i,
    output logic                 ready_o,
    output logic                 group_valid_o,
    output ofdm_pkg::bit_group_t group_o
);

    localparam int N_GROUPS = `OFDM_N_DATA / `OFDM_GROUP_SC;

    logic [1:0]     byte_cnt;
    logic [4:0]     grp_cnt;
    logic           mod_held_vld;
    ofdm_pkg::mod_t mod_held;
    ofdm_pkg::mod_t mod_in;
    ofdm_pkg::mod_t mod_cur;
    logic [1:0]     last_byte;
    logic           drain;
    logic           accept;
    logic           group_last;

    // fold the unused code onto BPSK
    always_comb
    begin
        case (mod_i)
            ofdm_pkg::QPSK:  mod_in = ofdm_pkg::QPSK;
            ofdm_pkg::QAM16: mod_in = ofdm_pkg::QAM16;
            default:         mod_in = ofdm_pkg::BPSK;
        endcase
    end

    // modulation is frozen after the first byte of a symbol
    assign mod_cur = mod_held_vld ? mod_held : mod_in;

    // bytes per group minus one
    always_comb
    begin
        case (mod_cur)
            ofdm_pkg::QPSK:  last_byte = 2'd1;
            ofdm_pkg::QAM16: last_byte = 2'd3;
            default:         last_byte = 2'd0;
        endcase
    end

    // drain keeps input closed for the last output cycle of a symbol
    assign ready_o    = !full_i && !drain && (grp_cnt < N_GROUPS);
    assign accept     = data_en_i && ready_o;
    assign group_last = accept && (byte_cnt == last_byte);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_cnt      <= '0;
            grp_cnt       <= '0;
            mod_held_vld  <= 1'b0;
            group_valid_o <= 1'b0;
            drain         <= 1'b0;
        end
        else
        begin
            group_valid_o <= group_last;
            drain         <= sym_end_i;
            if (sym_end_i)
            begin
                byte_cnt     <= '0;
                grp_cnt      <= '0;
                mod_held_vld <= 1'b0;
            end
            else if (accept)
            begin
                mod_held_vld <= 1'b1;
                if (group_last)
                begin
                    byte_cnt <= '0;
                    grp_cnt  <= grp_cnt + 5'd1;
                end
                else
                begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

    // first byte of a group lands in the lowest bits
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            if (!mod_held_vld)
                mod_held <= mod_in;
            group_o.bits[8*byte_cnt +: 8] <= data_i;
            group_o.mode                  <= mod_cur;
        end
    end

endmodule

//--- ofdm_subcarrier_mapper.sv
`timescale 1ns/1ps
`include "ofdm_defs.svh"

module ofdm_subcarrier_mapper
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   group_valid_i,
    input  ofdm_pkg::bit_group_t   group_i,
    output logic                   points_valid_o,
    output ofdm_pkg::point_group_t points_o
);

    localparam int W = `OFDM_SAMPLE_W;
    localparam logic signed [W-1:0] AMP1 = W'(`OFDM_AMP);
    localparam logic signed [W-1:0] AMP3 = W'(3 * `OFDM_AMP);

    ofdm_pkg::point_group_t mapped;

    // one bit per axis, BPSK and QPSK
    function automatic logic signed [W-1:0] level2(input logic b);
        return b ? AMP1 : -AMP1;
    endfunction

    // Gray coded pair, QAM16
    function automatic logic signed [W-1:0] level4(input logic [1:0] p);
        logic signed [W-1:0] v;
        case (p)
            2'b00:   v = -AMP3;
            2'b01:   v = -AMP1;
            2'b11:   v = AMP1;
            default: v = AMP3;
        endcase
        return v;
    endfunction

    //////////////////////////////
    // all eight subcarriers at once
    //////////////////////////////
    always_comb
    begin
        for (int k = 0; k < `OFDM_GROUP_SC; k++)
        begin
            case (group_i.mode)
                ofdm_pkg::QPSK:
                begin
                    mapped.sc[k].i = level2(group_i.bits[2*k]);
                    mapped.sc[k].q = level2(group_i.bits[2*k+1]);
                end
                ofdm_pkg::QAM16:
                begin
                    // lower pair on I, upper pair on Q
                    mapped.sc[k].i = level4(group_i.bits[4*k +: 2]);
                    mapped.sc[k].q = level4(group_i.bits[4*k+2 +: 2]);
                end
                default:
                begin
                    mapped.sc[k].i = level2(group_i.bits[k]);
                    mapped.sc[k].q = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            points_valid_o <= 1'b0;
        else
            points_valid_o <= group_valid_i;
    end

    always_ff @(posedge clk)
    begin
        if (group_valid_i)
            points_o <= mapped;
    end

endmodule

//--- ofdm_symbol_buffer.sv
`timescale 1ns/1ps
`include "ofdm_defs.svh"

module ofdm_symbol_buffer
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   points_valid_i,
    input  logic                   sym_end_i,
    input  ofdm_pkg::point_group_t points_i,
    input  logic [7:0]             rd_idx_i,
    output ofdm_pkg::cplx_t        rd_point_o,
    output logic                   full_o
);

    localparam int N_GROUPS = `OFDM_N_DATA / `OFDM_GROUP_SC;

    ofdm_pkg::cplx_t mem [0:`OFDM_N_DATA-1];
    logic [4:0]      wr_grp;
    logic [7:0]      wr_base;

    // eight entries per group
    assign wr_base = {wr_grp, 3'b000};

    always_ff @(posedge clk)
    begin
        if (points_valid_i)
        begin
            for (int k = 0; k < `OFDM_GROUP_SC; k++)
                mem[wr_base + 8'(k)] <= points_i.sc[k];
        end
    end

    // full rises together with the last group write
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_grp <= '0;
            full_o <= 1'b0;
        end
        else if (sym_end_i)
        begin
            wr_grp <= '0;
            full_o <= 1'b0;
        end
        else if (points_valid_i)
        begin
            wr_grp <= wr_grp + 5'd1;
            if (wr_grp == 5'(N_GROUPS - 1))
                full_o <= 1'b1;
        end
    end

    assign rd_point_o = mem[rd_idx_i];

endmodule

//--- ofdm_spectrum_writer.sv
`timescale 1ns/1ps
`include "ofdm_defs.svh"

module ofdm_spectrum_writer
(
    input  logic            clk,
    input  logic            reset,
    input  logic            full_i,
    input  logic            out_ready_i,
    input  ofdm_pkg::cplx_t rd_point_i,
    output logic [7:0]      rd_idx_o,
    output logic [7:0]      out_bin_o,
    output logic            sym_end_o,
    output logic            out_done_o,
    output logic            out_valid_o,
    output ofdm_pkg::cplx_t out_point_o
);

    localparam int W = `OFDM_SAMPLE_W;
    localparam logic signed [W-1:0] PILOT = W'(`OFDM_PILOT_AMP);

    logic [7:0]      bin_cnt;
    logic [7:0]      data_idx;
    logic            emit;
    logic            is_zero;
    logic            is_pilot_p;
    logic            is_pilot_n;
    logic            is_data;
    ofdm_pkg::cplx_t bin_point;

    assign emit      = full_i && out_ready_i;
    assign sym_end_o = emit && (bin_cnt == 8'd255);
    assign rd_idx_o  = data_idx;

    //////////////////////////////
    // bin classification
    //////////////////////////////
    always_comb
    begin
        // DC and guard band
        is_zero = (bin_cnt == 8'd0) ||
                  (bin_cnt >= `OFDM_GUARD_LO && bin_cnt <= `OFDM_GUARD_HI);
        is_pilot_p = (bin_cnt == `OFDM_PILOT_BIN_0) || (bin_cnt == `OFDM_PILOT_BIN_1) ||
                     (bin_cnt == `OFDM_PILOT_BIN_2) || (bin_cnt == `OFDM_PILOT_BIN_3);
        is_pilot_n = (bin_cnt == `OFDM_PILOT_BIN_4) || (bin_cnt == `OFDM_PILOT_BIN_5) ||
                     (bin_cnt == `OFDM_PILOT_BIN_6) || (bin_cnt == `OFDM_PILOT_BIN_7);
        is_data = !is_zero && !is_pilot_p && !is_pilot_n;
    end

    always_comb
    begin
        if (is_pilot_p)
        begin
            bin_point.i = PILOT;
            bin_point.q = '0;
        end
        else if (is_pilot_n)
        begin
            bin_point.i = -PILOT;
            bin_point.q = '0;
        end
        else if (is_zero)
        begin
            bin_point = '0;
        end
        else
        begin
            bin_point = rd_point_i;
        end
    end

    //////////////////////////////
    // bin and data counters
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bin_cnt     <= '0;
            data_idx    <= '0;
            out_valid_o <= 1'b0;
            out_done_o  <= 1'b0;
        end
        else
        begin
            out_valid_o <= emit;
            // stays up through the output cycle of bin 255
            out_done_o  <= full_i;
            if (emit)
            begin
                // wraps to 0 after bin 255
                bin_cnt <= bin_cnt + 8'd1;
                if (sym_end_o)
                    data_idx <= '0;
                else if (is_data)
                    data_idx <= data_idx + 8'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (emit)
        begin
            out_bin_o   <= bin_cnt;
            out_point_o <= bin_point;
        end
    end

endmodule

//--- ofdm_payload_gen.sv
`timescale 1ns/1ps

module ofdm_payload_gen
(
    input  logic            clk,
    input  logic            reset,
    input  logic            data_en_i,
    input  logic [7:0]      data_i,
    input  ofdm_pkg::mod_t  mod_i,
    input  logic            out_ready_i,
    output logic            ready_o,
    output logic            out_done_o,
    output logic            out_valid_o,
    output logic [7:0]      out_bin_o,
    output ofdm_pkg::cplx_t out_point_o
);

    ofdm_pkg::bit_group_t   group;
    logic                   group_valid;
    ofdm_pkg::point_group_t points;
    logic                   points_valid;
    logic                   full;
    logic                   sym_end;
    logic [7:0]             rd_idx;
    ofdm_pkg::cplx_t        rd_point;

    // bytes into groups
    ofdm_byte_packer ofdm_byte_packer_i
    (
        .clk           (clk),
        .reset         (reset),
        .data_en_i     (data_en_i),
        .data_i        (data_i),
        .mod_i         (mod_i),
        .sym_end_i     (sym_end),
        .full_i        (full),
        .ready_o       (ready_o),
        .group_valid_o (group_valid),
        .group_o       (group)
    );

    ofdm_subcarrier_mapper ofdm_subcarrier_mapper_i
    (
        .clk            (clk),
        .reset          (reset),
        .group_valid_i  (group_valid),
        .group_i        (group),
        .points_valid_o (points_valid),
        .points_o       (points)
    );

    ofdm_symbol_buffer ofdm_symbol_buffer_i
    (
        .clk            (clk),
        .reset          (reset),
        .points_valid_i (points_valid),
        .sym_end_i      (sym_end),
        .points_i       (points),
        .rd_idx_i       (rd_idx),
        .rd_point_o     (rd_point),
        .full_o         (full)
    );

    // bins out
    ofdm_spectrum_writer ofdm_spectrum_writer_i
    (
        .clk         (clk),
        .reset       (reset),
        .full_i      (full),
        .out_ready_i (out_ready_i),
        .rd_point_i  (rd_point),
        .rd_idx_o    (rd_idx),
        .out_bin_o   (out_bin_o),
        .sym_end_o   (sym_end),
        .out_done_o  (out_done_o),
        .out_valid_o (out_valid_o),
        .out_point_o (out_point_o)
    );

endmodule

//--- ofdm_payload_gen_checker.sv
`timescale 1ns/1ps

module ofdm_payload_gen_checker
(
    input logic       clk,
    input logic       reset,
    input logic       ready_i,
    input logic       done_i,
    input logic       valid_i,
    input logic [7:0] bin_i
);

    logic [7:0] last_bin;

    // 255 after reset so that bin 0 comes next
    always_ff @(posedge clk)
    begin
        if (reset)
            last_bin <= 8'hff;
        else if (valid_i)
            last_bin <= bin_i;
    end

    valid_in_done: assert property (@(posedge clk) disable iff (reset) valid_i |-> done_i)
        else $error("out_valid_o high while out_done_o is low");

    no_input_while_done: assert property (@(posedge clk) disable iff (reset)
        done_i |-> !ready_i)
        else $error("ready_o high while out_done_o is high");

    // wraps from 255 to 0 between symbols
    bin_step: assert property (@(posedge clk) disable iff (reset)
        valid_i |-> bin_i == last_bin + 8'd1)
        else $error("out_bin_o did not step by one");

    idle_after_reset: assert property (@(posedge clk) reset |=> !done_i && !valid_i)
        else $error("out_done_o or out_valid_o high after reset");

endmodule

bind ofdm_payload_gen ofdm_payload_gen_checker ofdm_payload_gen_checker_i
(
    .clk     (clk),
    .reset   (reset),
    .ready_i (ready_o),
    .done_i  (out_done_o),
    .valid_i (out_valid_o),
    .bin_i   (out_bin_o)
);

//--- tb_ofdm_payload_gen.sv
`timescale 1ns/1ps
`include "ofdm_defs.svh"

module tb_ofdm_payload_gen;

    localparam int CLK_HALF  = 2;
    localparam int N_SYMBOLS = 6;
    localparam int MAX_BYTES = 96;
    // stalled output can run well below full rate
    localparam int WATCHDOG_CYCLES = N_SYMBOLS * (MAX_BYTES + 3 * `OFDM_N_BINS) + 500;

    localparam logic signed [15:0] AMP1  = 16'(`OFDM_AMP);
    localparam logic signed [15:0] AMP3  = 16'(3 * `OFDM_AMP);
    localparam logic signed [15:0] PILOT = 16'(`OFDM_PILOT_AMP);

    logic            clk;
    logic            reset;
    logic            data_en_i;
    logic [7:0]      data_i;
    ofdm_pkg::mod_t  mod_i;
    logic            out_ready_i;
    logic            ready_o;
    logic            out_done_o;
    logic            out_valid_o;
    logic [7:0]      out_bin_o;
    ofdm_pkg::cplx_t out_point_o;

    logic [31:0] lfsr;
    logic [7:0]  sym_bytes [0:MAX_BYTES-1];
    logic [31:0] exp_bins [0:`OFDM_N_BINS-1];
    int          err_count;
    int          check_count;
    int          test_count;
    int          test_err_base;
    int          test_chk_base;

    ofdm_payload_gen ofdm_payload_gen_i
    (
        .clk         (clk),
        .reset       (reset),
        .data_en_i   (data_en_i),
        .data_i      (data_i),
        .mod_i       (mod_i),
        .out_ready_i (out_ready_i),
        .ready_o     (ready_o),
        .out_done_o  (out_done_o),
        .out_valid_o (out_valid_o),
        .out_bin_o   (out_bin_o),
        .out_point_o (out_point_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    //////////////////////////////
    // stimulus source
    //////////////////////////////

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    function automatic logic [7:0] take_bits(input int count);
        logic [7:0] v;
        v = '0;
        for (int b = 0; b < count; b++)
        begin
            v[b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic int bytes_for(input ofdm_pkg::mod_t mode);
        case (mode)
            ofdm_pkg::QPSK:  return 48;
            ofdm_pkg::QAM16: return 96;
            default:         return 24;
        endcase
    endfunction

    // a different mode, driven after the first byte
    function automatic ofdm_pkg::mod_t other_mod(input ofdm_pkg::mod_t mode);
        case (mode)
            ofdm_pkg::BPSK: return ofdm_pkg::QAM16;
            ofdm_pkg::QPSK: return ofdm_pkg::BPSK;
            default:        return ofdm_pkg::QPSK;
        endcase
    endfunction

    // bit idx of the symbol, byte 0 bit 0 first
    function automatic logic sym_bit(input int idx);
        return sym_bytes[idx / 8][idx % 8];
    endfunction

    function automatic logic signed [15:0] two_level(input logic b);
        return b ? AMP1 : -AMP1;
    endfunction

    // upper bit gives the sign, lower bit picks the inner ring
    function automatic logic signed [15:0] four_level(input logic hi, input logic lo);
        logic signed [15:0] mag;
        mag = lo ? AMP1 : AMP3;
        return hi ? mag : -mag;
    endfunction

    function automatic int pilot_sign(input int b);
        if (b == `OFDM_PILOT_BIN_0 || b == `OFDM_PILOT_BIN_1 ||
            b == `OFDM_PILOT_BIN_2 || b == `OFDM_PILOT_BIN_3)
            return 1;
        if (b == `OFDM_PILOT_BIN_4 || b == `OFDM_PILOT_BIN_5 ||
            b == `OFDM_PILOT_BIN_6 || b == `OFDM_PILOT_BIN_7)
            return -1;
        return 0;
    endfunction

    task automatic build_model(input ofdm_pkg::mod_t mode);
        int                 n;
        logic signed [15:0] vi;
        logic signed [15:0] vq;
        n = 0;
        for (int b = 0; b < `OFDM_N_BINS; b++)
        begin
            vi = '0;
            vq = '0;
            if (pilot_sign(b) > 0)
                vi = PILOT;
            else if (pilot_sign(b) < 0)
                vi = -PILOT;
            else if (b != 0 && (b < `OFDM_GUARD_LO || b > `OFDM_GUARD_HI))
            begin
                case (mode)
                    ofdm_pkg::QPSK:
                    begin
                        vi = two_level(sym_bit(2 * n));
                        vq = two_level(sym_bit(2 * n + 1));
                    end
                    ofdm_pkg::QAM16:
                    begin
                        vi = four_level(sym_bit(4 * n + 1), sym_bit(4 * n));
                        vq = four_level(sym_bit(4 * n + 3), sym_bit(4 * n + 2));
                    end
                    default:
                    begin
                        vi = two_level(sym_bit(n));
                    end
                endcase
                n++;
            end
            exp_bins[b] = {vi, vq};
        end
    endtask

    //////////////////////////////
    // drivers and checks
    //////////////////////////////

    task automatic check_level(input string name, input string sig,
                               input logic expv, input logic act);
        check_count++;
        assert (act === expv)
        else
        begin
            err_count++;
            $display("ERR %s %s: expected %0b actual %0b", name, sig, expv, act);
        end
    endtask

    task automatic check_bin(input string name, input int idx);
        check_count++;
        assert (out_bin_o == 8'(idx))
        else
        begin
            err_count++;
            $display("ERR %s bin index: expected %0d actual %0d", name, idx, out_bin_o);
        end
        check_count++;
        assert (out_point_o == exp_bins[idx])
        else
        begin
            err_count++;
            $display("ERR %s bin %0d: expected %h actual %h", name, idx, exp_bins[idx],
                     out_point_o);
        end
    endtask

    // mode only counts on the first byte
    task automatic send_bytes(input ofdm_pkg::mod_t mode, input int nbytes);
        int sent;
        sent = 0;
        while (sent < nbytes)
        begin
            @(negedge clk);
            if (ready_o)
            begin
                data_en_i = 1'b1;
                data_i    = sym_bytes[sent];
                mod_i     = (sent == 0) ? mode : other_mod(mode);
                sent++;
            end
            else
            begin
                data_en_i = 1'b0;
            end
        end
        @(negedge clk);
        data_en_i = 1'b0;
    endtask

    task automatic collect_bins(input string name, input logic stall, input logic junk);
        int         got;
        logic [7:0] rb;
        got = 0;
        while (got < `OFDM_N_BINS)
        begin
            @(negedge clk);
            if (out_valid_o)
            begin
                check_bin(name, got);
                got++;
            end
            rb          = take_bits(1);
            out_ready_i = stall ? rb[0] : 1'b1;
            // stray bytes while the symbol is going out
            data_en_i   = junk && out_done_o;
            if (junk)
                data_i = take_bits(8);
        end
    endtask

    task automatic wait_ready(input string name, input int limit);
        int cycles;
        cycles      = 0;
        out_ready_i = 1'b1;
        // a stray byte after bin 255 still meets the drain cycle
        while (!ready_o && cycles < limit)
        begin
            @(negedge clk);
            data_en_i = 1'b0;
            check_count++;
            assert (!out_valid_o)
            else
            begin
                err_count++;
                $display("%s: an extra bin %0d came out after bin 255", name, out_bin_o);
            end
            cycles++;
        end
        check_count++;
        assert (ready_o)
        else
        begin
            err_count++;
            $display("%s: ready_o did not return high within %0d cycles", name, limit);
        end
    endtask

    task automatic run_symbol(input string name, input ofdm_pkg::mod_t mode,
                              input logic stall, input logic junk);
        int nbytes;
        nbytes = bytes_for(mode);
        for (int j = 0; j < nbytes; j++)
            sym_bytes[j] = take_bits(8);
        build_model(mode);
        send_bytes(mode, nbytes);
        collect_bins(name, stall, junk);
        wait_ready(name, 2);
    endtask

    task automatic start_test();
        test_err_base = err_count;
        test_chk_base = check_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("%s: %0d checks, %0d errors", name, check_count - test_chk_base,
                 err_count - test_err_base);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_reset_state();
        start_test();
        @(negedge clk);
        check_level("reset_state", "ready_o", 1'b1, ready_o);
        check_level("reset_state", "out_done_o", 1'b0, out_done_o);
        check_level("reset_state", "out_valid_o", 1'b0, out_valid_o);
        end_test("reset_state");
    endtask

    task automatic test_bpsk();
        start_test();
        run_symbol("bpsk", ofdm_pkg::BPSK, 1'b0, 1'b0);
        end_test("bpsk");
    endtask

    task automatic test_qpsk_stall();
        start_test();
        run_symbol("qpsk_stall", ofdm_pkg::QPSK, 1'b1, 1'b0);
        end_test("qpsk_stall");
    endtask

    task automatic test_qam16_ignore();
        start_test();
        run_symbol("qam16_ignore", ofdm_pkg::QAM16, 1'b0, 1'b1);
        run_symbol("qam16_ignore", ofdm_pkg::QAM16, 1'b0, 1'b0);
        end_test("qam16_ignore");
    endtask

    task automatic test_back_to_back();
        start_test();
        run_symbol("back_to_back", ofdm_pkg::QAM16, 1'b0, 1'b0);
        run_symbol("back_to_back", ofdm_pkg::BPSK, 1'b0, 1'b0);
        end_test("back_to_back");
    endtask

    initial
    begin
        data_en_i   = 1'b0;
        data_i      = '0;
        mod_i       = ofdm_pkg::BPSK;
        out_ready_i = 1'b1;
        reset       = 1'b1;
        lfsr        = 32'he8c2f689;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_bpsk();
        test_qpsk_stall();
        test_qam16_ignore();
        test_back_to_back();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- ofdm_payload_gen.f
+incdir+.
ofdm_pkg.sv
ofdm_byte_packer.sv
ofdm_subcarrier_mapper.sv
ofdm_symbol_buffer.sv
ofdm_spectrum_writer.sv
ofdm_payload_gen.sv
ofdm_payload_gen_checker.sv
tb_ofdm_payload_gen.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the fail line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ofdm_payload_gen \
    -f ofdm_payload_gen.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; echo "simulation stopped with an error"; exit 1; }
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
